// File: source/daa_types_pkg.sv
/* Data-side types for the DAA unit: byte and nibble vectors, the flag word
   and the request/response bundles of the req/ack handshake */

`default_nettype none

package daa_types_pkg;

    // Accumulator and operand values
    typedef logic [7:0] byte_t;

    // Nibble used by the split adder and the digit compares
    typedef logic [3:0] nibble_t;

    // Architectural flags without bits 3 and 5
    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic pv;
        logic n;
        logic c;
    } flags_t;

    // Operand bundle held stable by the requester while req is high
    typedef struct packed {
        byte_t  a;
        flags_t flags;
    } daa_req_t;

    // Result bundle valid while ack is high
    typedef struct packed {
        byte_t  a;
        flags_t flags;
    } daa_rsp_t;

endpackage

`default_nettype wire

// File: source/daa_ctrl_pkg.sv
/* Control encodings for the DAA sequencer: timing states, correction
   constant select and the strobe word sent to the ALU and flag unit */

`default_nettype none

package daa_ctrl_pkg;

    typedef enum logic [2:0] {
        t_idle = 3'd0,
        t1     = 3'd1,
        t2     = 3'd2,
        t3     = 3'd3,
        t_done = 3'd4
    } tstate_t;

    // Bit 0 picks the low digit, bit 1 the high digit
    typedef enum logic [1:0] {
        corr_00 = 2'b00,
        corr_06 = 2'b01,
        corr_60 = 2'b10,
        corr_66 = 2'b11
    } corr_sel_t;

    // Per-state strobes
    typedef struct packed {
        logic      load;
        logic      cmp;
        logic      adjust;
        logic      sub;
        corr_sel_t corr;
        logic      write_a;
        logic      write_flags;
        logic      hold_tmp;
    } ctrl_t;

endpackage

`default_nettype wire

// File: source/daa_control.sv
/* Handshake, T-state sequencer and DAA decoder. Steps T1..T3 once per
   request and drives the strobes for the ALU and flag unit */

`timescale 1ns/1ps
`default_nettype none

module daa_control (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   req,
    input  wire                   tmp_low,
    input  wire                   tmp_high,
    input  daa_types_pkg::flags_t flags,
    output logic                  ack,
    output daa_ctrl_pkg::ctrl_t   ctrl
);

    import daa_ctrl_pkg::*;

    tstate_t state;
    logic    low_digit;
    logic    high_digit;

    // ==================================================================
    // Sequencer
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= t_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                t_idle: begin
                    if (req) begin
                        state <= t1;
                    end
                end
                t1: state <= t2;
                t2: state <= t3;
                t3: state <= t_done;
                t_done: begin
                    // Hold the response until the requester lets go
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= t_idle;
                    end
                end
                default: state <= t_idle;
            endcase
        end
    end

    // ==================================================================
    // Decoder
    // ==================================================================

    // Correction digits from the latched flags and the T2 compare
    assign low_digit  = flags.h | tmp_low;
    assign high_digit = flags.c | tmp_high;

    always_comb begin
        ctrl = '0;
        case (state)
            t1: begin
                ctrl.load = 1'b1;
            end
            t2: begin
                // A minus 0x9A
                ctrl.cmp = 1'b1;
                ctrl.sub = 1'b1;
            end
            t3: begin
                ctrl.adjust      = 1'b1;
                ctrl.sub         = flags.n;
                ctrl.corr        = corr_sel_t'({high_digit, low_digit});
                ctrl.write_a     = 1'b1;
                ctrl.write_flags = 1'b1;
                ctrl.hold_tmp    = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/daa_alu.sv
/* Accumulator and 8-bit nibble-split adder/subtractor. Compares against
   0x9A in T2 and applies the correction constant in T3 */

`timescale 1ns/1ps
`default_nettype none

module daa_alu (
    input  wire                   clk,
    input  wire                   rst_n,
    input  daa_ctrl_pkg::ctrl_t   ctrl,
    input  daa_types_pkg::byte_t  a_in,
    output daa_types_pkg::byte_t  result,
    output daa_types_pkg::byte_t  acc,
    output logic                  half_carry,
    output logic                  carry
);

    import daa_types_pkg::*;
    import daa_ctrl_pkg::*;

    localparam byte_t cmp_const = 8'h9a;

    byte_t      operand;
    nibble_t    a_lo;
    nibble_t    a_hi;
    nibble_t    b_lo;
    nibble_t    b_hi;
    logic [4:0] low_sum;
    logic [4:0] high_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (ctrl.load) begin
            acc <= a_in;
        end else if (ctrl.write_a) begin
            acc <= result;
        end
    end

    // Operand select
    always_comb begin
        operand = '0;
        if (ctrl.cmp) begin
            operand = cmp_const;
        end else if (ctrl.adjust) begin
            case (ctrl.corr)
                corr_06: operand = 8'h06;
                corr_60: operand = 8'h60;
                corr_66: operand = 8'h66;
                default: operand = 8'h00;
            endcase
        end
    end

    assign a_lo = acc[3:0];
    assign a_hi = acc[7:4];
    assign b_lo = operand[3:0];
    assign b_hi = operand[7:4];

    // Bit 4 of each half is carry on add and borrow on subtract
    always_comb begin
        if (ctrl.sub) begin
            low_sum  = {1'b0, a_lo} - {1'b0, b_lo};
            high_sum = {1'b0, a_hi} - {1'b0, b_hi} - {4'b0, low_sum[4]};
        end else begin
            low_sum  = {1'b0, a_lo} + {1'b0, b_lo};
            high_sum = {1'b0, a_hi} + {1'b0, b_hi} + {4'b0, low_sum[4]};
        end
    end

    assign result     = {high_sum[3:0], low_sum[3:0]};
    assign half_carry = low_sum[4];
    assign carry      = high_sum[4];

endmodule

`default_nettype wire

// File: source/daa_flag_unit.sv
/* Flag register with the two T2 temporaries. Loads the request flags in T1
   and writes S, Z, H, P/V and C from the ALU in T3 */

`timescale 1ns/1ps
`default_nettype none

module daa_flag_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  daa_ctrl_pkg::ctrl_t   ctrl,
    input  daa_types_pkg::flags_t flags_in,
    input  daa_types_pkg::byte_t  result,
    input  wire                   half_carry,
    input  wire                   carry,
    output daa_types_pkg::flags_t flags,
    output logic                  tmp_low,
    output logic                  tmp_high
);

    logic zero;
    logic parity_even;

    assign zero        = (result == 8'h00);
    assign parity_even = ~^result;

    // ==================================================================
    // Architectural flags
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ctrl.load) begin
            flags <= flags_in;
        end else if (ctrl.write_flags) begin
            flags.s  <= result[7];
            flags.z  <= zero;
            flags.h  <= half_carry;
            flags.pv <= parity_even;
            // N passes through unchanged
            flags.c  <= flags.c | tmp_high;
        end
    end

    // ==================================================================
    // Compare temporaries
    // ==================================================================

    // No borrow from A - 0x9A means the digit is out of BCD range
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tmp_low  <= 1'b0;
            tmp_high <= 1'b0;
        end else if (ctrl.cmp) begin
            tmp_low  <= ~half_carry;
            tmp_high <= ~carry;
        end else if (!ctrl.hold_tmp) begin
            tmp_low  <= 1'b0;
            tmp_high <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/daa_unit.sv
/* DAA unit top level. Joins the sequencer, ALU and flag unit behind a
   four-phase req/ack handshake with a fixed four-cycle latency */

`timescale 1ns/1ps
`default_nettype none

module daa_unit (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req,
    input  daa_types_pkg::daa_req_t req_data,
    output logic                    ack,
    output daa_types_pkg::daa_rsp_t rsp_data
);

    import daa_types_pkg::*;
    import daa_ctrl_pkg::*;

    ctrl_t  ctrl;
    byte_t  result;
    byte_t  acc;
    flags_t flags;
    logic   half_carry;
    logic   carry;
    logic   tmp_low;
    logic   tmp_high;

    daa_control i_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .tmp_low  (tmp_low),
        .tmp_high (tmp_high),
        .flags    (flags),
        .ack      (ack),
        .ctrl     (ctrl)
    );

    daa_alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .a_in       (req_data.a),
        .result     (result),
        .acc        (acc),
        .half_carry (half_carry),
        .carry      (carry)
    );

    daa_flag_unit i_flag_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .flags_in   (req_data.flags),
        .result     (result),
        .half_carry (half_carry),
        .carry      (carry),
        .flags      (flags),
        .tmp_low    (tmp_low),
        .tmp_high   (tmp_high)
    );

    assign rsp_data = '{a: acc, flags: flags};

endmodule

`default_nettype wire

// File: dv/tb_daa_unit.sv
/* Random-stimulus testbench for the DAA unit. Drives the req/ack handshake
   and checks every response and its latency against a DAA reference model */

`timescale 1ns/1ps
`default_nettype none

module tb_daa_unit;

    import daa_types_pkg::*;

    localparam int ack_timeout = 20;

    logic     clk;
    logic     rst_n;
    logic     req;
    daa_req_t req_data;
    logic     ack;
    daa_rsp_t rsp_data;

    logic [31:0] rng;
    int          errors;
    int          checks;
    byte_t       edge_vals [6] = '{8'h99, 8'h9a, 8'h09, 8'h0a, 8'hff, 8'h00};

    daa_unit i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // DAA reference with digit fixes from H/C or out-of-range nibbles
    function automatic daa_rsp_t daa_model(input daa_req_t r);
        daa_rsp_t rsp;
        logic     lo_fix;
        logic     hi_fix;
        byte_t    corr;
        lo_fix = r.flags.h || (r.a[3:0] > 4'd9);
        hi_fix = r.flags.c || (r.a > 8'h99);
        corr   = {(hi_fix ? 4'h6 : 4'h0), (lo_fix ? 4'h6 : 4'h0)};
        if (r.flags.n) begin
            rsp.a       = r.a - corr;
            rsp.flags.h = (r.a[3:0] < corr[3:0]);
        end else begin
            rsp.a       = r.a + corr;
            rsp.flags.h = (({1'b0, r.a[3:0]} + {1'b0, corr[3:0]}) > 5'd15);
        end
        rsp.flags.s  = rsp.a[7];
        rsp.flags.z  = (rsp.a == 8'h00);
        rsp.flags.pv = ~^rsp.a;
        rsp.flags.n  = r.flags.n;
        rsp.flags.c  = r.flags.c || (r.a > 8'h99);
        return rsp;
    endfunction

    function automatic daa_req_t random_request(input logic n);
        daa_req_t    r;
        logic [31:0] bits;
        bits    = next_random();
        r.a     = bits[7:0];
        r.flags = bits[13:8];
        r.flags.n = n;
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, got, expected);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("Error at %0t ns: timed out waiting for %s", $time, what);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    // One full four-phase transaction that holds req for extra cycles after ack
    task automatic run_request(input daa_req_t r, input int hold);
        daa_rsp_t expected;
        int       lat;
        expected = daa_model(r);
        check_value(ack, 1'b0, "ack low before request");
        req      = 1'b1;
        req_data = r;
        lat      = 0;
        @(negedge clk);
        while (!ack) begin
            lat++;
            if (lat > ack_timeout) begin
                abort_run("ack to rise");
            end
            @(negedge clk);
        end
        check_value(lat, 4, "ack latency after req sampled");
        check_value(rsp_data.a, expected.a, "result byte");
        check_value(rsp_data.flags, expected.flags, "result flags");
        check_value(rsp_data.flags.n, r.flags.n, "N carried through");
        repeat (hold) begin
            @(negedge clk);
            check_value(ack, 1'b1, "ack held while req high");
            check_value(rsp_data, expected, "rsp_data stable while ack high");
        end
        req = 1'b0;
        @(negedge clk);
        lat = 1;
        while (ack) begin
            lat++;
            if (lat > ack_timeout) begin
                abort_run("ack to fall");
            end
            @(negedge clk);
        end
        check_value(lat, 1, "ack fall after req drop");
    endtask

    initial begin
        daa_req_t    r;
        logic [31:0] rand_bits;
        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        rng      = 32'hcc8ec536;
        errors   = 0;
        checks   = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Reset state before any request
        check_value(ack, 1'b0, "ack after reset");
        check_value(rsp_data, '0, "rsp_data after reset");
        @(negedge clk);

        // Add side, then subtract side
        repeat (100) begin
            run_request(random_request(1'b0), next_random() % 7);
        end
        repeat (100) begin
            run_request(random_request(1'b1), next_random() % 7);
        end

        // Digit boundaries with every H/C pair on both sides
        foreach (edge_vals[i]) begin
            for (int hc = 0; hc < 8; hc++) begin
                r         = random_request(hc[2]);
                r.a       = edge_vals[i];
                r.flags.h = hc[0];
                r.flags.c = hc[1];
                run_request(r, next_random() % 7);
            end
        end

        // Back to back with random idle gaps
        repeat (300) begin
            rand_bits = next_random();
            run_request(random_request(rand_bits[0]), next_random() % 7);
            repeat (next_random() % 4) @(negedge clk);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/daa_types_pkg.sv
source/daa_ctrl_pkg.sv
source/daa_control.sv
source/daa_alu.sv
source/daa_flag_unit.sv
source/daa_unit.sv
dv/tb_daa_unit.sv

// File: Bender.yml
package:
  name: daa_unit

sources:
  - source/daa_types_pkg.sv
  - source/daa_ctrl_pkg.sv
  - source/daa_control.sv
  - source/daa_alu.sv
  - source/daa_flag_unit.sv
  - source/daa_unit.sv
  - target: test
    files:
      - dv/tb_daa_unit.sv
